//--- rtl/mips_ex_config.svh
`ifndef MIPS_EX_CONFIG_SVH
`define MIPS_EX_CONFIG_SVH

// ====================
// datapath sizes
// ====================

// width of every data and address word in the stage
`define MIPS_EX_DATA_W 32

// register file address width, 32 registers
`define MIPS_EX_REG_AW 5

// branch offset is a word offset
`define MIPS_EX_BR_SHIFT 2

`endif

//--- rtl/mips_ex_pkg.sv
`include "mips_ex_config.svh"

package mips_ex_pkg;

	// main alu operation from decode
	typedef enum logic [1:0] {
		op_add   = 2'b00,
		op_sub   = 2'b01,
		op_funct = 2'b10,
		op_other = 2'b11
	} alu_op_e;

	// alu control code, immediate ops drive it directly via the other field
	typedef enum logic [3:0] {
		ctrl_and = 4'b0000,
		ctrl_or  = 4'b0001,
		ctrl_add = 4'b0010,
		ctrl_xor = 4'b0011,
		ctrl_sll = 4'b0100,
		ctrl_srl = 4'b0101,
		ctrl_sub = 4'b0110,
		ctrl_slt = 4'b0111,
		ctrl_sra = 4'b1000,
		ctrl_lui = 4'b1001,
		ctrl_nor = 4'b1100
	} alu_ctrl_e;

	// ====================
	// stage payloads
	// ====================

	// all zero is a bubble for both structs
	typedef struct packed {
		logic                         regdst;
		logic                         alusrc;
		logic                         branch;
		logic                         memread;
		logic                         memwrite;
		logic                         memtoreg;
		logic                         regwrite;
		alu_op_e                      aluop;
		logic [3:0]                   other;
		logic [`MIPS_EX_DATA_W-1:0]   next_pc;
		logic [`MIPS_EX_DATA_W-1:0]   rs_data;
		logic [`MIPS_EX_DATA_W-1:0]   rt_data;
		logic [`MIPS_EX_DATA_W-1:0]   sign_ext;
		logic [`MIPS_EX_REG_AW-1:0]   rt_addr;
		logic [`MIPS_EX_REG_AW-1:0]   rd_addr;
	} id_ex_t;

	typedef struct packed {
		logic                         branch;
		logic                         memread;
		logic                         memwrite;
		logic                         memtoreg;
		logic                         regwrite;
		logic [`MIPS_EX_DATA_W-1:0]   branch_target;
		logic                         zero;
		logic [`MIPS_EX_DATA_W-1:0]   alu_result;
		logic [`MIPS_EX_DATA_W-1:0]   rt_data;
		logic [`MIPS_EX_REG_AW-1:0]   dest_addr;
	} ex_mem_t;

endpackage

//--- rtl/alu_control.sv
`timescale 1ns/10ps

module alu_control (
	input  mips_ex_pkg::alu_op_e   i_alu_op,
	input  logic [5:0]             i_funct,
	input  logic [3:0]             i_other,
	output mips_ex_pkg::alu_ctrl_e o_alu_ctrl
);

	mips_ex_pkg::alu_ctrl_e funct_ctrl;

	// r-type function field decode
	always_comb begin
		case (i_funct)
			6'h20, 6'h21: funct_ctrl = mips_ex_pkg::ctrl_add;
			6'h22, 6'h23: funct_ctrl = mips_ex_pkg::ctrl_sub;
			6'h24:        funct_ctrl = mips_ex_pkg::ctrl_and;
			6'h25:        funct_ctrl = mips_ex_pkg::ctrl_or;
			6'h26:        funct_ctrl = mips_ex_pkg::ctrl_xor;
			6'h27:        funct_ctrl = mips_ex_pkg::ctrl_nor;
			6'h2a:        funct_ctrl = mips_ex_pkg::ctrl_slt;
			6'h00:        funct_ctrl = mips_ex_pkg::ctrl_sll;
			6'h02:        funct_ctrl = mips_ex_pkg::ctrl_srl;
			6'h03:        funct_ctrl = mips_ex_pkg::ctrl_sra;
			// unknown function falls back to add
			default:      funct_ctrl = mips_ex_pkg::ctrl_add;
		endcase
	end

	// main op select
	always_comb begin
		case (i_alu_op)
			mips_ex_pkg::op_add:   o_alu_ctrl = mips_ex_pkg::ctrl_add;
			mips_ex_pkg::op_sub:   o_alu_ctrl = mips_ex_pkg::ctrl_sub;
			mips_ex_pkg::op_funct: o_alu_ctrl = funct_ctrl;
			// immediate ops, other field is already a control code
			default:               o_alu_ctrl = mips_ex_pkg::alu_ctrl_e'(i_other);
		endcase
	end

endmodule

//--- rtl/alu.sv
`timescale 1ns/10ps
`include "mips_ex_config.svh"

module alu (
	input  logic [`MIPS_EX_DATA_W-1:0] i_a,
	input  logic [`MIPS_EX_DATA_W-1:0] i_b,
	input  logic [4:0]                 i_shamt,
	input  mips_ex_pkg::alu_ctrl_e     i_alu_ctrl,
	output logic [`MIPS_EX_DATA_W-1:0] o_result,
	output logic                       o_zero
);

	localparam int half_w = `MIPS_EX_DATA_W / 2;

	logic [`MIPS_EX_DATA_W-1:0] result;

	// ====================
	// operation select
	// ====================
	always_comb begin
		case (i_alu_ctrl)
			mips_ex_pkg::ctrl_and: result = i_a & i_b;
			mips_ex_pkg::ctrl_or:  result = i_a | i_b;
			mips_ex_pkg::ctrl_xor: result = i_a ^ i_b;
			mips_ex_pkg::ctrl_nor: result = ~(i_a | i_b);
			mips_ex_pkg::ctrl_add: result = i_a + i_b;
			mips_ex_pkg::ctrl_sub: result = i_a - i_b;
			// signed compare, result is 1 or 0
			mips_ex_pkg::ctrl_slt: begin
				result = '0;
				result[0] = ($signed(i_a) < $signed(i_b));
			end
			// shifts act on operand b by shamt
			mips_ex_pkg::ctrl_sll: result = i_b << i_shamt;
			mips_ex_pkg::ctrl_srl: result = i_b >> i_shamt;
			mips_ex_pkg::ctrl_sra: result = $signed(i_b) >>> i_shamt;
			// low half of b moved up, low half cleared
			mips_ex_pkg::ctrl_lui: begin
				result = {i_b[half_w-1:0], {half_w{1'b0}}};
			end
			default:               result = '0;
		endcase
	end

	assign o_result = result;

	// zero flag for branch-equal
	assign o_zero = (result == '0);

endmodule

//--- rtl/stage_reg.sv
`timescale 1ns/10ps

module stage_reg #(
	parameter type payload_t = logic [31:0]
) (
	input  logic     i_clk,
	input  logic     i_rst_n,
	input  logic     i_hold,
	input  logic     i_clear,
	input  payload_t i_d,
	output payload_t o_q
);

	payload_t q;

	// clear beats hold, a cleared stage is a bubble
	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			q <= '0;
		end else if (i_clear) begin
			q <= '0;
		end else if (!i_hold) begin
			q <= i_d;
		end
	end

	assign o_q = q;

endmodule

//--- rtl/execute.sv
`timescale 1ns/10ps
`include "mips_ex_config.svh"

module execute (
	input  logic                       i_regdst,
	input  logic                       i_alusrc,
	input  mips_ex_pkg::alu_op_e       i_alu_op,
	input  logic [3:0]                 i_other,
	input  logic [`MIPS_EX_DATA_W-1:0] i_next_pc,
	input  logic [`MIPS_EX_DATA_W-1:0] i_rs_data,
	input  logic [`MIPS_EX_DATA_W-1:0] i_rt_data,
	input  logic [`MIPS_EX_DATA_W-1:0] i_sign_ext,
	input  logic [`MIPS_EX_REG_AW-1:0] i_rt_addr,
	input  logic [`MIPS_EX_REG_AW-1:0] i_rd_addr,
	output logic [`MIPS_EX_DATA_W-1:0] o_branch_target,
	output logic                       o_zero,
	output logic [`MIPS_EX_DATA_W-1:0] o_alu_result,
	output logic [`MIPS_EX_REG_AW-1:0] o_dest_addr
);

	logic [`MIPS_EX_DATA_W-1:0] operand_b;
	logic [`MIPS_EX_DATA_W-1:0] br_offset;
	logic [5:0]                 funct;
	logic [4:0]                 shamt;
	mips_ex_pkg::alu_ctrl_e     alu_ctrl;

	// ====================
	// muxes and adder
	// ====================

	// rt for r-type and branch, immediate for loads, stores and i-type
	assign operand_b = i_alusrc ? i_sign_ext : i_rt_data;

	// rd for r-type, rt otherwise
	assign o_dest_addr = i_regdst ? i_rd_addr : i_rt_addr;

	// funct and shamt live in the low bits of the immediate
	assign funct = i_sign_ext[5:0];
	assign shamt = i_sign_ext[10:6];

	// word offset to byte offset
	assign br_offset = i_sign_ext << `MIPS_EX_BR_SHIFT;
	assign o_branch_target = i_next_pc + br_offset;

	// ====================
	// alu
	// ====================
	alu_control u_alu_control (
		.i_alu_op   (i_alu_op),
		.i_funct    (funct),
		.i_other    (i_other),
		.o_alu_ctrl (alu_ctrl)
	);

	alu u_alu (
		.i_a        (i_rs_data),
		.i_b        (operand_b),
		.i_shamt    (shamt),
		.i_alu_ctrl (alu_ctrl),
		.o_result   (o_alu_result),
		.o_zero     (o_zero)
	);

endmodule

//--- rtl/ex_stage_top.sv
`timescale 1ns/10ps
`include "mips_ex_config.svh"

module ex_stage_top (
	input  logic                       i_clk,
	input  logic                       i_rst_n,
	input  logic                       i_stall,
	input  logic                       i_flush,
	input  logic                       i_regdst,
	input  logic                       i_alusrc,
	input  logic                       i_branch,
	input  logic                       i_memread,
	input  logic                       i_memwrite,
	input  logic                       i_memtoreg,
	input  logic                       i_regwrite,
	input  mips_ex_pkg::alu_op_e       i_alu_op,
	input  logic [3:0]                 i_other,
	input  logic [`MIPS_EX_DATA_W-1:0] i_next_pc,
	input  logic [`MIPS_EX_DATA_W-1:0] i_rs_data,
	input  logic [`MIPS_EX_DATA_W-1:0] i_rt_data,
	input  logic [`MIPS_EX_DATA_W-1:0] i_sign_ext,
	input  logic [`MIPS_EX_REG_AW-1:0] i_rt_addr,
	input  logic [`MIPS_EX_REG_AW-1:0] i_rd_addr,
	output logic                       o_branch,
	output logic                       o_memread,
	output logic                       o_memwrite,
	output logic                       o_memtoreg,
	output logic                       o_regwrite,
	output logic [`MIPS_EX_DATA_W-1:0] o_branch_target,
	output logic                       o_zero,
	output logic [`MIPS_EX_DATA_W-1:0] o_alu_result,
	output logic [`MIPS_EX_DATA_W-1:0] o_rt_data,
	output logic [`MIPS_EX_REG_AW-1:0] o_dest_addr
);

	mips_ex_pkg::id_ex_t  id_ex_d;
	mips_ex_pkg::id_ex_t  id_ex_q;
	mips_ex_pkg::ex_mem_t ex_mem_d;
	mips_ex_pkg::ex_mem_t ex_mem_q;

	logic [`MIPS_EX_DATA_W-1:0] ex_branch_target;
	logic                       ex_zero;
	logic [`MIPS_EX_DATA_W-1:0] ex_alu_result;
	logic [`MIPS_EX_REG_AW-1:0] ex_dest_addr;

	// ====================
	// id/ex register
	// ====================
	assign id_ex_d = '{
		regdst:   i_regdst,
		alusrc:   i_alusrc,
		branch:   i_branch,
		memread:  i_memread,
		memwrite: i_memwrite,
		memtoreg: i_memtoreg,
		regwrite: i_regwrite,
		aluop:    i_alu_op,
		other:    i_other,
		next_pc:  i_next_pc,
		rs_data:  i_rs_data,
		rt_data:  i_rt_data,
		sign_ext: i_sign_ext,
		rt_addr:  i_rt_addr,
		rd_addr:  i_rd_addr
	};

	// stall holds the stage, flush turns it into a bubble
	stage_reg #(
		.payload_t (mips_ex_pkg::id_ex_t)
	) u_id_ex (
		.i_clk   (i_clk),
		.i_rst_n (i_rst_n),
		.i_hold  (i_stall),
		.i_clear (i_flush),
		.i_d     (id_ex_d),
		.o_q     (id_ex_q)
	);

	// ====================
	// execute
	// ====================
	execute u_execute (
		.i_regdst        (id_ex_q.regdst),
		.i_alusrc        (id_ex_q.alusrc),
		.i_alu_op        (id_ex_q.aluop),
		.i_other         (id_ex_q.other),
		.i_next_pc       (id_ex_q.next_pc),
		.i_rs_data       (id_ex_q.rs_data),
		.i_rt_data       (id_ex_q.rt_data),
		.i_sign_ext      (id_ex_q.sign_ext),
		.i_rt_addr       (id_ex_q.rt_addr),
		.i_rd_addr       (id_ex_q.rd_addr),
		.o_branch_target (ex_branch_target),
		.o_zero          (ex_zero),
		.o_alu_result    (ex_alu_result),
		.o_dest_addr     (ex_dest_addr)
	);

	// ====================
	// ex/mem register
	// ====================

	// memory and write-back controls ride along unchanged
	assign ex_mem_d = '{
		branch:        id_ex_q.branch,
		memread:       id_ex_q.memread,
		memwrite:      id_ex_q.memwrite,
		memtoreg:      id_ex_q.memtoreg,
		regwrite:      id_ex_q.regwrite,
		branch_target: ex_branch_target,
		zero:          ex_zero,
		alu_result:    ex_alu_result,
		rt_data:       id_ex_q.rt_data,
		dest_addr:     ex_dest_addr
	};

	stage_reg #(
		.payload_t (mips_ex_pkg::ex_mem_t)
	) u_ex_mem (
		.i_clk   (i_clk),
		.i_rst_n (i_rst_n),
		.i_hold  (i_stall),
		.i_clear (i_flush),
		.i_d     (ex_mem_d),
		.o_q     (ex_mem_q)
	);

	assign o_branch        = ex_mem_q.branch;
	assign o_memread       = ex_mem_q.memread;
	assign o_memwrite      = ex_mem_q.memwrite;
	assign o_memtoreg      = ex_mem_q.memtoreg;
	assign o_regwrite      = ex_mem_q.regwrite;
	assign o_branch_target = ex_mem_q.branch_target;
	assign o_zero          = ex_mem_q.zero;
	assign o_alu_result    = ex_mem_q.alu_result;
	assign o_rt_data       = ex_mem_q.rt_data;
	assign o_dest_addr     = ex_mem_q.dest_addr;

endmodule

//--- testbench/tb_ex_stage.sv
`timescale 1ns/10ps
`include "mips_ex_config.svh"

module tb_ex_stage;

	localparam int clk_period  = 20;
	// length of all tests in cycles, the watchdog allows twice this
	localparam int test_cycles = 100;

	logic clk;
	logic rst_n;
	logic stall;
	logic flush;
	mips_ex_pkg::id_ex_t drv;

	logic                       out_branch;
	logic                       out_memread;
	logic                       out_memwrite;
	logic                       out_memtoreg;
	logic                       out_regwrite;
	logic [`MIPS_EX_DATA_W-1:0] out_branch_target;
	logic                       out_zero;
	logic [`MIPS_EX_DATA_W-1:0] out_alu_result;
	logic [`MIPS_EX_DATA_W-1:0] out_rt_data;
	logic [`MIPS_EX_REG_AW-1:0] out_dest_addr;

	// model state: what ID/EX holds and what EX/MEM should show
	mips_ex_pkg::id_ex_t  mdl_idex;
	mips_ex_pkg::ex_mem_t exp_out;

	integer seed = 32'h1957;
	int     err_count = 0;
	int     check_count = 0;

	ex_stage_top u_dut (
		.i_clk           (clk),
		.i_rst_n         (rst_n),
		.i_stall         (stall),
		.i_flush         (flush),
		.i_regdst        (drv.regdst),
		.i_alusrc        (drv.alusrc),
		.i_branch        (drv.branch),
		.i_memread       (drv.memread),
		.i_memwrite      (drv.memwrite),
		.i_memtoreg      (drv.memtoreg),
		.i_regwrite      (drv.regwrite),
		.i_alu_op        (drv.aluop),
		.i_other         (drv.other),
		.i_next_pc       (drv.next_pc),
		.i_rs_data       (drv.rs_data),
		.i_rt_data       (drv.rt_data),
		.i_sign_ext      (drv.sign_ext),
		.i_rt_addr       (drv.rt_addr),
		.i_rd_addr       (drv.rd_addr),
		.o_branch        (out_branch),
		.o_memread       (out_memread),
		.o_memwrite      (out_memwrite),
		.o_memtoreg      (out_memtoreg),
		.o_regwrite      (out_regwrite),
		.o_branch_target (out_branch_target),
		.o_zero          (out_zero),
		.o_alu_result    (out_alu_result),
		.o_rt_data       (out_rt_data),
		.o_dest_addr     (out_dest_addr)
	);

	initial begin
		clk = 1'b0;
		forever #(clk_period / 2) clk = ~clk;
	end

	initial begin
		#(clk_period * test_cycles * 2);
		$display("timeout: tests still running after %0d cycles", test_cycles * 2);
		$display("TEST RESULT: FAIL");
		$finish;
	end

	// ====================
	// reference model
	// ====================
	function automatic mips_ex_pkg::alu_ctrl_e funct_op(logic [5:0] funct);
		case (funct)
			6'h20, 6'h21: return mips_ex_pkg::ctrl_add;
			6'h22, 6'h23: return mips_ex_pkg::ctrl_sub;
			6'h24:        return mips_ex_pkg::ctrl_and;
			6'h25:        return mips_ex_pkg::ctrl_or;
			6'h26:        return mips_ex_pkg::ctrl_xor;
			6'h27:        return mips_ex_pkg::ctrl_nor;
			6'h2a:        return mips_ex_pkg::ctrl_slt;
			6'h00:        return mips_ex_pkg::ctrl_sll;
			6'h02:        return mips_ex_pkg::ctrl_srl;
			6'h03:        return mips_ex_pkg::ctrl_sra;
			default:      return mips_ex_pkg::ctrl_add;
		endcase
	endfunction

	function automatic mips_ex_pkg::ex_mem_t predict(mips_ex_pkg::id_ex_t d);
		mips_ex_pkg::ex_mem_t       e;
		mips_ex_pkg::alu_ctrl_e     op;
		logic [`MIPS_EX_DATA_W-1:0] b;
		logic [4:0]                 sh;
		e = '0;
		b = d.alusrc ? d.sign_ext : d.rt_data;
		sh = d.sign_ext[10:6];
		case (d.aluop)
			mips_ex_pkg::op_add:   op = mips_ex_pkg::ctrl_add;
			mips_ex_pkg::op_sub:   op = mips_ex_pkg::ctrl_sub;
			mips_ex_pkg::op_other: op = mips_ex_pkg::alu_ctrl_e'(d.other);
			default:               op = funct_op(d.sign_ext[5:0]);
		endcase
		case (op)
			mips_ex_pkg::ctrl_and: e.alu_result = d.rs_data & b;
			mips_ex_pkg::ctrl_or:  e.alu_result = d.rs_data | b;
			mips_ex_pkg::ctrl_xor: e.alu_result = d.rs_data ^ b;
			mips_ex_pkg::ctrl_nor: e.alu_result = ~(d.rs_data | b);
			mips_ex_pkg::ctrl_add: e.alu_result = d.rs_data + b;
			mips_ex_pkg::ctrl_sub: e.alu_result = d.rs_data - b;
			mips_ex_pkg::ctrl_slt: e.alu_result = ($signed(d.rs_data) < $signed(b)) ? 32'd1 : 32'd0;
			mips_ex_pkg::ctrl_sll: e.alu_result = b << sh;
			mips_ex_pkg::ctrl_srl: e.alu_result = b >> sh;
			mips_ex_pkg::ctrl_sra: e.alu_result = $signed(b) >>> sh;
			mips_ex_pkg::ctrl_lui: e.alu_result = {b[15:0], 16'h0000};
			default:               e.alu_result = '0;
		endcase
		e.zero = (e.alu_result == '0);
		// word offset times four
		e.branch_target = d.next_pc + d.sign_ext * 4;
		e.dest_addr = d.regdst ? d.rd_addr : d.rt_addr;
		e.rt_data = d.rt_data;
		e.branch = d.branch;
		e.memread = d.memread;
		e.memwrite = d.memwrite;
		e.memtoreg = d.memtoreg;
		e.regwrite = d.regwrite;
		return e;
	endfunction

	// ====================
	// compare tasks
	// ====================
	task automatic check_data(string name, logic [`MIPS_EX_DATA_W-1:0] got,
			logic [`MIPS_EX_DATA_W-1:0] exp);
		check_count++;
		if (got !== exp) begin
			err_count++;
			$display("MISMATCH %s: got 0x%h, expected 0x%h at %0t", name, got, exp, $time);
		end
	endtask

	task automatic check_addr(string name, logic [`MIPS_EX_REG_AW-1:0] got,
			logic [`MIPS_EX_REG_AW-1:0] exp);
		check_count++;
		if (got !== exp) begin
			err_count++;
			$display("MISMATCH %s: got 0x%h, expected 0x%h at %0t", name, got, exp, $time);
		end
	endtask

	task automatic check_bit(string name, logic got, logic exp);
		check_count++;
		if (got !== exp) begin
			err_count++;
			$display("MISMATCH %s: got 0x%h, expected 0x%h at %0t", name, got, exp, $time);
		end
	endtask

	// branch, memread, memwrite, memtoreg, regwrite as one group
	task automatic check_ctrl(string name, logic [4:0] got, logic [4:0] exp);
		check_count++;
		if (got !== exp) begin
			err_count++;
			$display("MISMATCH %s: got 0x%h, expected 0x%h at %0t", name, got, exp, $time);
		end
	endtask

	task automatic compare_outputs();
		check_ctrl("o_branch/o_memread/o_memwrite/o_memtoreg/o_regwrite",
			{out_branch, out_memread, out_memwrite, out_memtoreg, out_regwrite},
			{exp_out.branch, exp_out.memread, exp_out.memwrite, exp_out.memtoreg,
				exp_out.regwrite});
		check_data("o_branch_target", out_branch_target, exp_out.branch_target);
		check_bit("o_zero", out_zero, exp_out.zero);
		check_data("o_alu_result", out_alu_result, exp_out.alu_result);
		check_data("o_rt_data", out_rt_data, exp_out.rt_data);
		check_addr("o_dest_addr", out_dest_addr, exp_out.dest_addr);
	endtask

	// one clock edge: advance the model, then check once outputs settle
	task automatic tick();
		@(posedge clk);
		if (flush) begin
			exp_out = '0;
			mdl_idex = '0;
		end else if (!stall) begin
			exp_out = predict(mdl_idex);
			mdl_idex = drv;
		end
		#2;
		compare_outputs();
	endtask

	task automatic drain(int n);
		drv = '0;
		repeat (n) tick();
	endtask

	task automatic report_test(string name, int errs_before);
		if (err_count == errs_before)
			$display("%s: done, no errors", name);
		else
			$display("%s: done, %0d errors", name, err_count - errs_before);
	endtask

	// ====================
	// stimulus helpers
	// ====================
	function automatic logic [`MIPS_EX_DATA_W-1:0] rand_word();
		return $random(seed);
	endfunction

	function automatic logic [`MIPS_EX_DATA_W-1:0] sext16(logic [15:0] imm);
		return {{(`MIPS_EX_DATA_W-16){imm[15]}}, imm};
	endfunction

	// random data and addresses, every control inactive
	function automatic mips_ex_pkg::id_ex_t rand_instr();
		mips_ex_pkg::id_ex_t        d;
		logic [`MIPS_EX_DATA_W-1:0] w;
		d = '0;
		w = rand_word();
		d.next_pc = {w[31:2], 2'b00};
		d.rs_data = rand_word();
		d.rt_data = rand_word();
		w = rand_word();
		d.rt_addr = w[4:0];
		d.rd_addr = w[9:5];
		d.sign_ext = sext16(w[31:16]);
		return d;
	endfunction

	function automatic mips_ex_pkg::id_ex_t make_rtype(logic [5:0] funct, logic same);
		mips_ex_pkg::id_ex_t d;
		d = rand_instr();
		d.regdst = 1'b1;
		d.regwrite = 1'b1;
		d.aluop = mips_ex_pkg::op_funct;
		if (same)
			d.rt_data = d.rs_data;
		// low half of an r-type word is rd, shamt, funct
		d.sign_ext = sext16({d.rd_addr, d.sign_ext[10:6], funct});
		return d;
	endfunction

	// ====================
	// tests
	// ====================
	task automatic run_reset_test();
		int errs_before;
		errs_before = err_count;
		repeat (10) @(posedge clk);
		#2;
		rst_n = 1'b1;
		compare_outputs();
		drain(2);
		report_test("reset", errs_before);
	endtask

	task automatic run_rtype_test();
		logic [5:0] functs [0:12];
		int         errs_before;
		errs_before = err_count;
		functs = '{6'h20, 6'h21, 6'h22, 6'h23, 6'h24, 6'h25, 6'h26, 6'h27,
			6'h2a, 6'h00, 6'h02, 6'h03, 6'h3f};
		// back to back, so two instructions are always in flight
		for (int i = 0; i < 13; i++) begin
			for (int r = 0; r < 3; r++) begin
				drv = make_rtype(functs[i], r == 0);
				tick();
			end
		end
		drain(2);
		report_test("r_type", errs_before);
	endtask

	task automatic run_load_store_test();
		mips_ex_pkg::id_ex_t d;
		int                  errs_before;
		errs_before = err_count;
		for (int i = 0; i < 8; i++) begin
			d = rand_instr();
			d.alusrc = 1'b1;
			d.aluop = mips_ex_pkg::op_add;
			// even slots load, odd slots store
			d.memread = (i % 2 == 0);
			d.memwrite = ~d.memread;
			d.memtoreg = d.memread;
			d.regwrite = d.memread;
			drv = d;
			tick();
		end
		drain(2);
		report_test("load_store", errs_before);
	endtask

	task automatic run_branch_test();
		mips_ex_pkg::id_ex_t d;
		int                  errs_before;
		errs_before = err_count;
		for (int i = 0; i < 6; i++) begin
			d = rand_instr();
			d.branch = 1'b1;
			d.aluop = mips_ex_pkg::op_sub;
			if (i < 3)
				d.rt_data = d.rs_data;
			else
				d.rt_data = d.rs_data ^ (rand_word() | 32'd1);
			drv = d;
			tick();
		end
		drain(2);
		report_test("branch_equal", errs_before);
	endtask

	task automatic run_imm_test();
		mips_ex_pkg::alu_ctrl_e ops [0:4];
		mips_ex_pkg::id_ex_t    d;
		int                     errs_before;
		errs_before = err_count;
		// andi, ori, xori, slti, lui
		ops = '{mips_ex_pkg::ctrl_and, mips_ex_pkg::ctrl_or, mips_ex_pkg::ctrl_xor,
			mips_ex_pkg::ctrl_slt, mips_ex_pkg::ctrl_lui};
		for (int i = 0; i < 10; i++) begin
			d = rand_instr();
			d.alusrc = 1'b1;
			d.regwrite = 1'b1;
			d.aluop = mips_ex_pkg::op_other;
			d.other = ops[i % 5];
			drv = d;
			tick();
		end
		drain(2);
		report_test("immediate", errs_before);
	endtask

	task automatic run_stall_flush_test();
		int errs_before;
		errs_before = err_count;
		// held stall, the offered instruction is ignored until release
		drv = make_rtype(6'h20, 1'b0);
		tick();
		drv = make_rtype(6'h22, 1'b0);
		stall = 1'b1;
		repeat (4) tick();
		stall = 1'b0;
		drain(2);
		// flush with an instruction pending in ID/EX
		drv = make_rtype(6'h25, 1'b0);
		tick();
		drv = make_rtype(6'h26, 1'b0);
		flush = 1'b1;
		tick();
		flush = 1'b0;
		drain(3);
		// flush wins over stall
		drv = make_rtype(6'h24, 1'b0);
		tick();
		drv = make_rtype(6'h2a, 1'b0);
		tick();
		stall = 1'b1;
		flush = 1'b1;
		tick();
		stall = 1'b0;
		flush = 1'b0;
		drain(2);
		report_test("stall_flush", errs_before);
	endtask

	initial begin
		rst_n = 1'b0;
		stall = 1'b0;
		flush = 1'b0;
		drv = '0;
		mdl_idex = '0;
		exp_out = '0;
		run_reset_test();
		run_rtype_test();
		run_load_store_test();
		run_branch_test();
		run_imm_test();
		run_stall_flush_test();
		$display("summary: %0d checks, %0d errors", check_count, err_count);
		if (err_count == 0) begin
			$display("TEST RESULT: PASS");
		end else begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end

endmodule

//--- mips_ex.f
+incdir+rtl
rtl/mips_ex_pkg.sv
rtl/alu_control.sv
rtl/alu.sv
rtl/stage_reg.sv
rtl/execute.sv
rtl/ex_stage_top.sv
testbench/tb_ex_stage.sv

//--- Makefile
SIM        ?= verilator
TOP        ?= tb_ex_stage
FILELIST   ?= mips_ex.f
BUILD_DIR  ?= obj_dir
SIM_FLAGS  ?= --binary --timing -j 0
LINT_FLAGS ?= --lint-only --timing
PASS_STR   := TEST RESULT: PASS

.PHONY: all lint sim clean

all: sim

lint:
	$(SIM) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(SIM) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_STR)"

clean:
	rm -rf $(BUILD_DIR)
